/* hw/exu_isa_pkg.sv */
////////////////////////////////////////////////////////////
// widths and encodings of the instruction set that the
// execute stage runs; imported by every stage block
////////////////////////////////////////////////////////////

package exu_isa_pkg;

    // data and address width
    localparam int XLEN       = 32;
    // register index width
    localparam int REG_ADDR_W = 5;

    // decoded opcode as handed over by the issue logic
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU
    } exu_op_e;

    // operations the ALU knows about
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // divider sequence
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_e;

endpackage

/* hw/exu_bus_pkg.sv */
////////////////////////////////////////////////////////////
// structs carried between the issue logic, the dispatcher
// and the execution units of the execute stage
////////////////////////////////////////////////////////////

package exu_bus_pkg;

    import exu_isa_pkg::*;

    // one decoded instruction with its operands
    typedef struct packed {
        logic                  valid;
        exu_op_e               op;
        logic                  use_imm;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
    } issue_t;

    // register file write port
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

    // fetch redirect
    typedef struct packed {
        logic            flag;
        logic [XLEN-1:0] addr;
    } jump_t;

    typedef struct packed {
        logic                  req;
        alu_op_e               op;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [REG_ADDR_W-1:0] rd;
    } alu_req_t;

    // target is already resolved by the dispatcher
    typedef struct packed {
        logic            req;
        exu_op_e         op;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        logic [XLEN-1:0] target;
    } bru_req_t;

    typedef struct packed {
        logic                  req;
        logic                  is_signed;
        logic                  want_rem;
        logic [XLEN-1:0]       dividend;
        logic [XLEN-1:0]       divisor;
        logic [REG_ADDR_W-1:0] rd;
    } div_req_t;

endpackage

/* hw/exu_dispatch.sv */
////////////////////////////////////////////////////////////
// sorts an issued instruction onto the ALU, branch unit or
// divider and prepares their operands; purely combinational
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exu_dispatch
    import exu_isa_pkg::*;
    import exu_bus_pkg::*;
(
    input  issue_t   issue_i,
    input  logic     div_busy_i,
    output alu_req_t alu_req_o,
    output bru_req_t bru_req_o,
    output div_req_t div_req_o
);

    logic            accept;
    logic            is_jump;
    logic            to_alu;
    logic            to_bru;
    logic            to_div;
    alu_op_e         alu_op;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] jalr_sum;

    // nothing leaves here while the divider runs
    assign accept   = issue_i.valid && !div_busy_i;
    assign is_jump  = (issue_i.op == OP_JAL) || (issue_i.op == OP_JALR);
    assign to_bru   = issue_i.op inside {[OP_BEQ:OP_JALR]};
    assign to_div   = issue_i.op inside {[OP_DIV:OP_REMU]};
    assign op2      = issue_i.use_imm ? issue_i.imm : issue_i.rs2_data;
    assign jalr_sum = issue_i.rs1_data + issue_i.imm;

    // opcode to ALU operation, jumps reuse the adder for the link value
    always_comb begin
        to_alu = 1'b1;
        alu_op = ALU_ADD;
        case (issue_i.op)
            OP_ADD:          alu_op = ALU_ADD;
            OP_SUB:          alu_op = ALU_SUB;
            OP_SLL:          alu_op = ALU_SLL;
            OP_SLT:          alu_op = ALU_SLT;
            OP_SLTU:         alu_op = ALU_SLTU;
            OP_XOR:          alu_op = ALU_XOR;
            OP_SRL:          alu_op = ALU_SRL;
            OP_SRA:          alu_op = ALU_SRA;
            OP_OR:           alu_op = ALU_OR;
            OP_AND:          alu_op = ALU_AND;
            OP_JAL, OP_JALR: alu_op = ALU_ADD;
            default:         to_alu = 1'b0;
        endcase
    end

    always_comb begin
        alu_req_o.req = accept && to_alu;
        alu_req_o.op  = alu_op;
        alu_req_o.op1 = is_jump ? issue_i.pc : issue_i.rs1_data;
        alu_req_o.op2 = is_jump ? XLEN'(4) : op2;
        alu_req_o.rd  = issue_i.rd;

        // branches always compare the two registers
        bru_req_o.req = accept && to_bru;
        bru_req_o.op  = issue_i.op;
        bru_req_o.op1 = issue_i.rs1_data;
        bru_req_o.op2 = issue_i.rs2_data;
        if (issue_i.op == OP_JALR) begin
            bru_req_o.target = {jalr_sum[XLEN-1:1], 1'b0};
        end else begin
            bru_req_o.target = issue_i.pc + issue_i.imm;
        end

        div_req_o.req       = accept && to_div;
        div_req_o.is_signed = (issue_i.op == OP_DIV) || (issue_i.op == OP_REM);
        div_req_o.want_rem  = (issue_i.op == OP_REM) || (issue_i.op == OP_REMU);
        div_req_o.dividend  = issue_i.rs1_data;
        div_req_o.divisor   = issue_i.rs2_data;
        div_req_o.rd        = issue_i.rd;
    end

    // one unit per instruction, jumps count once although the ALU writes the link
    always_comb begin
        assert final ($onehot0({alu_req_o.req && !is_jump, bru_req_o.req, div_req_o.req}))
            else $error("dispatch raised requests to more than one unit");
    end

endmodule

/* hw/exu_alu.sv */
////////////////////////////////////////////////////////////
// integer ALU; the result is registered and leaves as a
// write-back one cycle after the request
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exu_alu
    import exu_isa_pkg::*;
    import exu_bus_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  alu_req_t alu_req_i,
    output wb_t      alu_wb_o
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    result;

    assign shamt = alu_req_i.op2[SHAMT_W-1:0];

    always_comb begin
        case (alu_req_i.op)
            ALU_ADD:  result = alu_req_i.op1 + alu_req_i.op2;
            ALU_SUB:  result = alu_req_i.op1 - alu_req_i.op2;
            ALU_SLL:  result = alu_req_i.op1 << shamt;
            ALU_SLT:  result = XLEN'($signed(alu_req_i.op1) < $signed(alu_req_i.op2));
            ALU_SLTU: result = XLEN'(alu_req_i.op1 < alu_req_i.op2);
            ALU_XOR:  result = alu_req_i.op1 ^ alu_req_i.op2;
            ALU_SRL:  result = alu_req_i.op1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(alu_req_i.op1) >>> shamt);
            ALU_OR:   result = alu_req_i.op1 | alu_req_i.op2;
            ALU_AND:  result = alu_req_i.op1 & alu_req_i.op2;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            alu_wb_o.we <= 1'b0;
        end else begin
            alu_wb_o.we <= alu_req_i.req;
        end
        // payload only moves with a request
        if (alu_req_i.req) begin
            alu_wb_o.rd   <= alu_req_i.rd;
            alu_wb_o.data <= result;
        end
    end

endmodule

/* hw/exu_bru.sv */
////////////////////////////////////////////////////////////
// branch unit; compares the operands and registers the
// redirect so that it pulses one cycle after the request
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exu_bru
    import exu_isa_pkg::*;
    import exu_bus_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  bru_req_t bru_req_i,
    output jump_t    jump_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic taken;

    assign eq   = bru_req_i.op1 == bru_req_i.op2;
    assign lt_s = $signed(bru_req_i.op1) < $signed(bru_req_i.op2);
    assign lt_u = bru_req_i.op1 < bru_req_i.op2;

    always_comb begin
        case (bru_req_i.op)
            OP_BEQ:          taken = eq;
            OP_BNE:          taken = !eq;
            OP_BLT:          taken = lt_s;
            OP_BGE:          taken = !lt_s;
            OP_BLTU:         taken = lt_u;
            OP_BGEU:         taken = !lt_u;
            // unconditional
            OP_JAL, OP_JALR: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            jump_o.flag <= 1'b0;
        end else begin
            jump_o.flag <= bru_req_i.req && taken;
        end
        if (bru_req_i.req) begin
            jump_o.addr <= bru_req_i.target;
        end
    end

    // back to back redirects need back to back requests
    assert property (@(posedge clk) disable iff (reset_i)
        jump_o.flag && $past(jump_o.flag)
            |-> $past(bru_req_i.req) && $past(bru_req_i.req, 2))
        else $error("jump flag held without a new branch request");

endmodule

/* hw/exu_div.sv */
////////////////////////////////////////////////////////////
// radix-2 restoring divider for DIV/DIVU/REM/REMU; holds the
// issuer while busy and writes back from its DONE state
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exu_div
    import exu_isa_pkg::*;
    import exu_bus_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic     clk,
    input  logic     reset_i,
    input  div_req_t div_req_i,
    output logic     div_busy_o,
    output logic     hold_o,
    output wb_t      div_wb_o
);

    localparam int CNT_W = $clog2(XLEN);

    div_state_e            state_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [XLEN-1:0]       quot_q;
    logic [XLEN-1:0]       rem_q;
    logic [XLEN-1:0]       dsor_q;
    logic                  q_neg_q;
    logic                  r_neg_q;
    logic                  want_rem_q;
    logic                  zero_q;
    logic                  ovf_q;
    logic [REG_ADDR_W-1:0] rd_q;

    logic                  start;
    logic                  neg_dvnd;
    logic                  neg_dsor;
    logic [XLEN-1:0]       dvnd_mag;
    logic [XLEN-1:0]       dsor_mag;
    logic                  div_zero;
    logic                  div_ovf;
    logic [XLEN:0]         partial;
    logic [XLEN:0]         trial;
    logic                  step_ge;
    logic [XLEN-1:0]       quot_fix;
    logic [XLEN-1:0]       rem_fix;

    assign start = div_req_i.req && (state_q == IDLE);

    // operand signs and magnitudes
    assign neg_dvnd = div_req_i.is_signed && div_req_i.dividend[XLEN-1];
    assign neg_dsor = div_req_i.is_signed && div_req_i.divisor[XLEN-1];
    assign dvnd_mag = neg_dvnd ? -div_req_i.dividend : div_req_i.dividend;
    assign dsor_mag = neg_dsor ? -div_req_i.divisor : div_req_i.divisor;

    // cases that skip the loop
    assign div_zero = div_req_i.divisor == '0;
    assign div_ovf  = div_req_i.is_signed
                    && (div_req_i.dividend == {1'b1, {(XLEN-1){1'b0}}})
                    && (div_req_i.divisor == '1);

    // one restoring step, next dividend bit shifted into the remainder
    assign partial = {rem_q, quot_q[XLEN-1]};
    assign trial   = partial - {1'b0, dsor_q};
    assign step_ge = partial >= {1'b0, dsor_q};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (div_req_i.req) begin
                        state_q <= (div_zero || div_ovf) ? DONE : RUN;
                    end
                end
                RUN: begin
                    if (cnt_q == CNT_W'(XLEN - 1)) begin
                        state_q <= DONE;
                    end
                end
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cnt_q      <= '0;
            rem_q      <= '0;
            dsor_q     <= dsor_mag;
            // special cases keep the raw dividend for the result
            quot_q     <= (div_zero || div_ovf) ? div_req_i.dividend : dvnd_mag;
            q_neg_q    <= neg_dvnd ^ neg_dsor;
            r_neg_q    <= neg_dvnd;
            want_rem_q <= div_req_i.want_rem;
            zero_q     <= div_zero;
            ovf_q      <= div_ovf;
            rd_q       <= div_req_i.rd;
        end else if (state_q == RUN) begin
            cnt_q  <= cnt_q + 1'b1;
            quot_q <= {quot_q[XLEN-2:0], step_ge};
            rem_q  <= step_ge ? trial[XLEN-1:0] : partial[XLEN-1:0];
        end
    end

    // sign fix-up and the RISC-V corner cases
    always_comb begin
        quot_fix = q_neg_q ? -quot_q : quot_q;
        rem_fix  = r_neg_q ? -rem_q : rem_q;
        if (zero_q) begin
            quot_fix = '1;
            rem_fix  = quot_q;
        end else if (ovf_q) begin
            quot_fix = quot_q;
            rem_fix  = '0;
        end
    end

    assign div_busy_o    = state_q != IDLE;
    // high already in the accepting cycle
    assign hold_o        = div_req_i.req || div_busy_o;

    assign div_wb_o.we   = state_q == DONE;
    assign div_wb_o.rd   = rd_q;
    assign div_wb_o.data = want_rem_q ? rem_fix : quot_fix;

    // dispatch must mask new divides while busy
    assert property (@(posedge clk) disable iff (reset_i)
        div_req_i.req |-> !div_busy_o)
        else $error("divide request while the divider is busy");

    // write-back only right after a special-case load or the last loop step
    assert property (@(posedge clk) disable iff (reset_i)
        div_wb_o.we |-> $past(start && (div_zero || div_ovf))
            || (($past(state_q) == RUN) && ($past(cnt_q) == CNT_W'(XLEN - 1))))
        else $error("divider write-back outside the end of a divide");

endmodule

/* hw/exu_top.sv */
////////////////////////////////////////////////////////////
// execute stage top; dispatch feeding ALU, branch unit and
// divider, with the hold going back to the issuer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exu_top
    import exu_isa_pkg::*;
    import exu_bus_pkg::*;
(
    input  logic   clk,
    input  logic   reset_i,
    input  issue_t issue_i,
    output wb_t    alu_wb_o,
    output wb_t    div_wb_o,
    output jump_t  jump_o,
    output logic   hold_o
);

    alu_req_t alu_req;
    bru_req_t bru_req;
    div_req_t div_req;
    logic     div_busy;

    exu_dispatch u_exu_dispatch (
        .issue_i   (issue_i),
        .div_busy_i(div_busy),
        .alu_req_o (alu_req),
        .bru_req_o (bru_req),
        .div_req_o (div_req)
    );

    exu_alu u_alu (
        .clk      (clk),
        .reset_i  (reset_i),
        .alu_req_i(alu_req),
        .alu_wb_o (alu_wb_o)
    );

    exu_bru u_bru (
        .clk      (clk),
        .reset_i  (reset_i),
        .bru_req_i(bru_req),
        .jump_o   (jump_o)
    );

    exu_div #(
        .XLEN(XLEN)
    ) u_div (
        .clk       (clk),
        .reset_i   (reset_i),
        .div_req_i (div_req),
        .div_busy_o(div_busy),
        .hold_o    (hold_o),
        .div_wb_o  (div_wb_o)
    );

endmodule

/* include/exu_tb_vectors.svh */
////////////////////////////////////////////////////////////
// directed rows for the execute stage testbench; included
// inside the testbench module, after the row() helper
////////////////////////////////////////////////////////////

`ifndef EXU_TB_VECTORS_SVH
`define EXU_TB_VECTORS_SVH

localparam int N_VEC = 35;

// columns: op, use_imm, pc, rs1, rs2, imm, rd, kind, expected data, expected target
task automatic fill_vectors();
    vec[0]  = row(OP_ADD,  0, 0, 32'h5, 32'h7, 0, 1, K_ALU, 32'hC, 0);
    vec[1]  = row(OP_ADD,  1, 0, 32'h10, 0, 32'hFFFF_FFFF, 2, K_ALU, 32'hF, 0);
    vec[2]  = row(OP_SUB,  0, 0, 32'h3, 32'h5, 0, 3, K_ALU, 32'hFFFF_FFFE, 0);
    // shift amounts above 31 only use the low 5 bits
    vec[3]  = row(OP_SLL,  1, 0, 32'h1, 0, 32'h24, 4, K_ALU, 32'h10, 0);
    vec[4]  = row(OP_SLT,  0, 0, 32'hFFFF_FFFF, 32'h1, 0, 5, K_ALU, 32'h1, 0);
    vec[5]  = row(OP_SLTU, 0, 0, 32'hFFFF_FFFF, 32'h1, 0, 6, K_ALU, 32'h0, 0);
    vec[6]  = row(OP_XOR,  1, 0, 32'hF0F0_F0F0, 0, 32'h0FF0_0FF0, 7, K_ALU, 32'hFF00_FF00, 0);
    vec[7]  = row(OP_SRL,  0, 0, 32'h8000_0000, 32'h21, 0, 8, K_ALU, 32'h4000_0000, 0);
    vec[8]  = row(OP_SRA,  1, 0, 32'h8000_0000, 0, 32'h4, 9, K_ALU, 32'hF800_0000, 0);
    vec[9]  = row(OP_OR,   0, 0, 32'h1234_0000, 32'h5678, 0, 10, K_ALU, 32'h1234_5678, 0);
    vec[10] = row(OP_AND,  1, 0, 32'hDEAD_BEEF, 0, 32'hFFFF, 11, K_ALU, 32'hBEEF, 0);
    // branches, taken then not taken
    vec[11] = row(OP_BEQ,  0, 32'h100, 9, 9, 32'h20, 0, K_JUMP, 0, 32'h120);
    vec[12] = row(OP_BEQ,  0, 32'h100, 9, 8, 32'h20, 0, K_NOTAKEN, 0, 0);
    vec[13] = row(OP_BNE,  0, 32'h200, 1, 2, 32'hFFFF_FFF0, 0, K_JUMP, 0, 32'h1F0);
    vec[14] = row(OP_BNE,  0, 32'h200, 3, 3, 32'h10, 0, K_NOTAKEN, 0, 0);
    vec[15] = row(OP_BLT,  0, 32'h300, 32'hFFFF_FFFF, 1, 8, 0, K_JUMP, 0, 32'h308);
    vec[16] = row(OP_BLT,  0, 32'h300, 1, 32'hFFFF_FFFF, 8, 0, K_NOTAKEN, 0, 0);
    vec[17] = row(OP_BGE,  0, 32'h400, 1, 32'hFFFF_FFFF, 32'h10, 0, K_JUMP, 0, 32'h410);
    vec[18] = row(OP_BGE,  0, 32'h400, 32'hFFFF_FFFF, 1, 32'h10, 0, K_NOTAKEN, 0, 0);
    vec[19] = row(OP_BLTU, 0, 32'h500, 1, 32'hFFFF_FFFF, 4, 0, K_JUMP, 0, 32'h504);
    vec[20] = row(OP_BLTU, 0, 32'h500, 32'hFFFF_FFFF, 1, 4, 0, K_NOTAKEN, 0, 0);
    vec[21] = row(OP_BGEU, 0, 32'h600, 32'hFFFF_FFFF, 1, 32'hC, 0, K_JUMP, 0, 32'h60C);
    vec[22] = row(OP_BGEU, 0, 32'h600, 1, 32'hFFFF_FFFF, 32'hC, 0, K_NOTAKEN, 0, 0);
    // jumps write the link and redirect in the same cycle
    vec[23] = row(OP_JAL,  0, 32'h1000, 0, 0, 32'h40, 1, K_ALU_JUMP, 32'h1004, 32'h1040);
    vec[24] = row(OP_JALR, 1, 32'h2000, 32'h3001, 0, 32'h10, 1, K_ALU_JUMP, 32'h2004, 32'h3010);
    vec[25] = row(OP_DIV,  0, 0, 32'hFFFF_FFF9, 2, 0, 12, K_DIV, 32'hFFFF_FFFD, 0);
    vec[26] = row(OP_REM,  0, 0, 32'hFFFF_FFF9, 2, 0, 13, K_DIV, 32'hFFFF_FFFF, 0);
    vec[27] = row(OP_DIVU, 0, 0, 32'hFFFF_FFFE, 2, 0, 14, K_DIV, 32'h7FFF_FFFF, 0);
    vec[28] = row(OP_REMU, 0, 0, 32'd100, 7, 0, 15, K_DIV, 32'h2, 0);
    // divide by zero and signed overflow
    vec[29] = row(OP_DIV,  0, 0, 5, 0, 0, 16, K_DIV, 32'hFFFF_FFFF, 0);
    vec[30] = row(OP_REM,  0, 0, 5, 0, 0, 17, K_DIV, 32'h5, 0);
    vec[31] = row(OP_DIV,  0, 0, 32'h8000_0000, 32'hFFFF_FFFF, 0, 18, K_DIV, 32'h8000_0000, 0);
    vec[32] = row(OP_REM,  0, 0, 32'h8000_0000, 32'hFFFF_FFFF, 0, 19, K_DIV, 32'h0, 0);
    vec[33] = row(OP_DIVU, 0, 0, 9, 0, 0, 20, K_DIV, 32'hFFFF_FFFF, 0);
    vec[34] = row(OP_REMU, 0, 0, 9, 0, 0, 21, K_DIV, 32'h9, 0);
endtask

`endif

/* testbench/exu_tb.sv */
////////////////////////////////////////////////////////////
// testbench for the execute stage; runs the directed table,
// random divides and a hold scenario, then reports
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module exu_tb
    import exu_isa_pkg::*;
    import exu_bus_pkg::*;
();

    typedef enum logic [2:0] {K_ALU, K_JUMP, K_ALU_JUMP, K_NOTAKEN, K_DIV} kind_e;

    typedef struct packed {
        issue_t iss;
        kind_e  kind;
        wb_t    exp_wb;
        jump_t  exp_jump;
    } vec_t;

    localparam int N_RAND = 12;

    logic   clk;
    logic   reset_i;
    issue_t issue_i;
    wb_t    alu_wb_o;
    wb_t    div_wb_o;
    jump_t  jump_o;
    logic   hold_o;

    int     err_cnt;
    int     test_cnt;
    int     seed;
    vec_t   vec[64];

    exu_top dut_i (
        .clk     (clk),
        .reset_i (reset_i),
        .issue_i (issue_i),
        .alu_wb_o(alu_wb_o),
        .div_wb_o(div_wb_o),
        .jump_o  (jump_o),
        .hold_o  (hold_o)
    );

    always #50 clk = ~clk;

    function automatic vec_t row(exu_op_e op, logic imm_f, logic [XLEN-1:0] pc,
                                 logic [XLEN-1:0] rs1, logic [XLEN-1:0] rs2,
                                 logic [XLEN-1:0] imm, logic [REG_ADDR_W-1:0] rd,
                                 kind_e k, logic [XLEN-1:0] data, logic [XLEN-1:0] addr);
        vec_t v;
        v.iss = '{valid: 1'b1, op: op, use_imm: imm_f, pc: pc, rs1_data: rs1,
                  rs2_data: rs2, imm: imm, rd: rd};
        v.kind = k;
        v.exp_wb = '{we: k inside {K_ALU, K_ALU_JUMP, K_DIV}, rd: rd, data: data};
        v.exp_jump = '{flag: k inside {K_JUMP, K_ALU_JUMP}, addr: addr};
        return v;
    endfunction

    `include "exu_tb_vectors.svh"

    // divide model from the RISC-V rules
    function automatic logic [XLEN-1:0] ref_div(exu_op_e op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic                   ovf;
        sa  = a;
        sb  = b;
        ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        if (b == '0) begin
            return (op == OP_DIV || op == OP_DIVU) ? '1 : a;
        end
        case (op)
            OP_DIV:  return ovf ? a : $unsigned(sa / sb);
            OP_REM:  return ovf ? '0 : $unsigned(sa % sb);
            OP_DIVU: return a / b;
            default: return a % b;
        endcase
    endfunction

    task automatic check_wb(wb_t got, wb_t exp, string name);
        if (got.we !== exp.we || (exp.we && (got.rd !== exp.rd || got.data !== exp.data))) begin
            $display("** Error %s: got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_jump(jump_t got, jump_t exp);
        if (got.flag !== exp.flag || (exp.flag && got.addr !== exp.addr)) begin
            $display("** Error jump_o: got %h expected %h", got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_hold(logic exp);
        if (hold_o !== exp) begin
            $display("** Error hold_o: got %h expected %h", hold_o, exp);
            err_cnt++;
        end
    endtask

    // waits for the divider write-back, hold must stay high meanwhile
    task automatic wait_div(wb_t exp);
        int n;
        n = 0;
        while (div_wb_o.we !== 1'b1 && n < XLEN + 3) begin
            check_hold(1'b1);
            @(posedge clk);
            #1;
            issue_i.valid = 1'b0;
            n++;
        end
        if (div_wb_o.we !== 1'b1) begin
            $display("divider gave no write-back within %0d cycles, state %s",
                     XLEN + 3, dut_i.u_div.state_q.name());
            err_cnt++;
        end
        check_wb(div_wb_o, exp, "div_wb_o");
        check_hold(1'b1);
        @(posedge clk);
        #1;
        check_hold(1'b0);
    endtask

    task automatic run_row(vec_t v);
        int errs_before;
        errs_before = err_cnt;
        issue_i = v.iss;
        #1;
        if (v.kind == K_DIV) begin
            wait_div(v.exp_wb);
        end else begin
            @(posedge clk);
            #1;
            issue_i.valid = 1'b0;
            check_wb(alu_wb_o, v.exp_wb, "alu_wb_o");
            check_jump(jump_o, v.exp_jump);
        end
        $display("test %0d %s %s", test_cnt, v.iss.op.name(),
                 (err_cnt == errs_before) ? "pass" : "fail");
        test_cnt++;
    endtask

    // divide in flight while an add waits at the issue port
    task automatic run_hold_test();
        int   errs_before;
        vec_t div_v;
        vec_t add_v;
        errs_before = err_cnt;
        div_v = row(OP_DIVU, 0, 0, 32'd1000, 7, 0, 5, K_DIV, 0, 0);
        add_v = row(OP_ADD, 0, 0, 1, 2, 0, 6, K_ALU, 0, 0);
        issue_i = div_v.iss;
        @(posedge clk);
        #1;
        issue_i = add_v.iss;
        while (div_wb_o.we !== 1'b1 && hold_o === 1'b1) begin
            check_wb(alu_wb_o, '0, "alu_wb_o");
            @(posedge clk);
            #1;
        end
        check_wb(div_wb_o, '{we: 1'b1, rd: 5, data: 32'd142}, "div_wb_o");
        @(posedge clk);
        #1;
        check_hold(1'b0);
        check_wb(alu_wb_o, '0, "alu_wb_o");
        // the waiting add is accepted in this cycle
        @(posedge clk);
        #1;
        issue_i.valid = 1'b0;
        check_wb(alu_wb_o, '{we: 1'b1, rd: 6, data: 32'd3}, "alu_wb_o");
        $display("test %0d hold %s", test_cnt, (err_cnt == errs_before) ? "pass" : "fail");
        test_cnt++;
    endtask

    initial begin
        #((N_VEC + N_RAND + 3) * (XLEN + 10) * 100);
        $display("watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        exu_op_e         op;
        clk      = 1'b0;
        reset_i  = 1'b1;
        issue_i  = '0;
        err_cnt  = 0;
        test_cnt = 0;
        seed     = 32'h130c_efd1;
        fill_vectors();
        // random divides, every fourth with a small divisor
        for (int i = 0; i < N_RAND; i++) begin
            a  = $random(seed);
            b  = $random(seed);
            if (i % 4 == 3) begin
                b = b & 32'hF;
            end
            op = exu_op_e'(int'(OP_DIV) + (i % 4));
            vec[N_VEC + i] = row(op, 0, 0, a, b, 0, REG_ADDR_W'(i + 1), K_DIV,
                                 ref_div(op, a, b), 0);
        end
        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;
        check_wb(alu_wb_o, '0, "alu_wb_o");
        check_wb(div_wb_o, '0, "div_wb_o");
        check_jump(jump_o, '0);
        check_hold(1'b0);
        for (int i = 0; i < N_VEC + N_RAND; i++) begin
            run_row(vec[i]);
        end
        run_hold_test();
        $display("tests run %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+include
hw/exu_isa_pkg.sv
hw/exu_bus_pkg.sv
hw/exu_dispatch.sv
hw/exu_alu.sv
hw/exu_bru.sv
hw/exu_div.sv
hw/exu_top.sv
testbench/exu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module exu_tb -o exu_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/exu_sim > sim.log 2>&1
grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } || \
    grep -q "TB PASSED" sim.log && echo "simulation passed" || { echo "no result in sim.log"; exit 1; }
